// ==== src.f ====
hw/gb_isa_pkg.sv
hw/gb_core_pkg.sv
hw/gb_irq_ctrl.sv
hw/gb_decoder.sv
hw/gb_scheduler.sv
hw/gb_alu.sv
hw/gb_regfile.sv
hw/gb_cpu.sv
sim/tb_clock_gen.sv
sim/tb_gb_cpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
TOP       := tb_gb_cpu
FILELIST  := src.f
OBJ_DIR   := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_gb_cpu.sv ====
`default_nettype none

module tb_gb_cpu;
    logic        clk;
    logic        reset;
    logic [7:0]  cpu_data;
    logic [4:0]  reg_if;
    logic [4:0]  reg_ie;
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        drive;
    logic        clr_irq;

    logic [7:0]  mem [0:65535];
    logic [15:0] code_pc;
    logic [15:0] exp_addr_q [$];
    logic [7:0]  exp_data_q [$];
    logic [15:0] wr_addr_q [$];
    logic [7:0]  wr_data_q [$];
    logic [7:0]  m_a;
    logic        m_z, m_c;
    logic        wr_en;
    logic [15:0] wr_addr;
    logic [7:0]  wr_data;
    logic        irq_seen;
    logic        table_ready;
    int          irq_pulses;

    tb_clock_gen u_clk (
        .clk_o   (clk),
        .reset_o (reset)
    );

    gb_cpu u_dut (
        .clk              (clk),
        .reset            (reset),
        .data_i           (cpu_data),
        .reg_if_i         (reg_if),
        .reg_ie_i         (reg_ie),
        .addr_o           (addr),
        .data_o           (wdata),
        .drive_data_bus_o (drive),
        .clear_irq_o      (clr_irq)
    );

    // Reads answer in the same cycle
    assign cpu_data = mem[addr];

    task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (exp !== act) begin
            $display("** Error at time %0t: %s expected %h, got %h", $time, name, exp, act);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Program and expectation builders

    task automatic emit(input logic [7:0] b);
        mem[code_pc] = b;
        code_pc      = code_pc + 16'd1;
    endtask

    task automatic expect_write(input logic [15:0] a, input logic [7:0] d);
        exp_addr_q.push_back(a);
        exp_data_q.push_back(d);
    endtask

    // Reference flag rules returning {z, n, h, c, value}
    function automatic logic [11:0] alu_model(input logic [2:0] op, input logic [7:0] a,
                                              input logic [7:0] b, input logic cin);
        int         full;
        int         half;
        int         ci;
        logic [7:0] res;
        logic       n, h, c;
        ci = (op == 3'd1 || op == 3'd3) ? int'(cin) : 0;
        n  = 1'b0;
        h  = 1'b0;
        c  = 1'b0;
        case (op)
            3'd0, 3'd1: begin
                full = int'(a) + int'(b) + ci;
                half = int'(a[3:0]) + int'(b[3:0]) + ci;
                h    = (half > 15);
                c    = (full > 255);
                res  = full[7:0];
            end
            3'd2, 3'd3, 3'd7: begin
                full = int'(a) - int'(b) - ci;
                half = int'(a[3:0]) - int'(b[3:0]) - ci;
                n    = 1'b1;
                h    = (half < 0);
                c    = (full < 0);
                res  = full[7:0];
            end
            3'd4: begin
                res = a & b;
                h   = 1'b1;
            end
            3'd5:    res = a ^ b;
            default: res = a | b;
        endcase
        return {res == 8'h00, n, h, c, res};
    endfunction

    // LD A,a then LD D,b then op A,D with an optional store to (HL)
    task automatic run_alu(input logic [2:0] op, input logic [7:0] a, input logic [7:0] b,
                           input logic store);
        logic [11:0] r;
        emit(8'h3E);
        emit(a);
        emit(8'h16);
        emit(b);
        emit(8'h82 | {2'b00, op, 3'b000});
        r   = alu_model(op, a, b, m_c);
        m_a = (op == 3'd7) ? a : r[7:0];
        m_z = r[11];
        m_c = r[8];
        if (store) begin
            emit(8'h77);
            expect_write(16'hC000, m_a);
        end
    endtask

    // Fall-through stores mark and the jump target stores mark+1
    task automatic jp_case(input logic [1:0] k, input logic [7:0] mark);
        logic [15:0] tgt;
        logic [15:0] join_addr;
        logic        taken;
        tgt       = code_pc + 16'd9;
        join_addr = code_pc + 16'd12;
        case (k)
            2'd0:    taken = ~m_z;
            2'd1:    taken = m_z;
            2'd2:    taken = ~m_c;
            default: taken = m_c;
        endcase
        emit(8'hC2 | {3'b000, k, 3'b000});
        emit(tgt[7:0]);
        emit(tgt[15:8]);
        emit(8'h3E);
        emit(mark);
        emit(8'h77);
        emit(8'hC3);
        emit(join_addr[7:0]);
        emit(join_addr[15:8]);
        emit(8'h3E);
        emit(mark + 8'd1);
        emit(8'h77);
        expect_write(16'hC000, taken ? mark + 8'd1 : mark);
    endtask

    function automatic logic [4:0] lowest_bit(input logic [4:0] v);
        return v & (~v + 5'd1);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Bus monitor, memory writes and interrupt flag model

    always @(negedge clk) begin
        wr_en   = drive & ~reset;
        wr_addr = addr;
        wr_data = wdata;
        if (wr_en) begin
            wr_addr_q.push_back(addr);
            wr_data_q.push_back(wdata);
        end
        if (clr_irq && !reset) begin
            irq_pulses = irq_pulses + 1;
            irq_seen   = 1'b1;
        end
    end

    always @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        if (irq_seen) begin
            irq_seen = 1'b0;
            #10;
            reg_if = reg_if & ~lowest_bit(reg_if & reg_ie);
        end
    end

    // Outputs must stay quiet while reset is held
    initial begin
        while (reset !== 1'b0) begin
            @(negedge clk);
            if (reset) begin
                check_value("drive_data_bus_o", 16'd0, {15'd0, drive});
                check_value("clear_irq_o", 16'd0, {15'd0, clr_irq});
            end
        end
    end

    initial begin
        wait (table_ready);
        repeat ((exp_addr_q.size() + 3) * 20) @(posedge clk);
        $display("Timeout: the expected bus writes did not all appear in time");
        $display("*** FAILED ***");
        $fatal(1);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        logic [15:0] a16;
        logic [15:0] ret_addr;
        logic [15:0] self_addr;
        logic [7:0]  r0;
        logic [7:0]  r1;
        logic [7:0]  r2;
        logic [7:0]  r3;
        int          i;
        void'($urandom(48980));
        reg_if      = 5'b00101;
        reg_ie      = 5'h1F;
        irq_pulses  = 0;
        irq_seen    = 1'b0;
        wr_en       = 1'b0;
        table_ready = 1'b0;
        m_c         = 1'b0;
        for (i = 0; i < 65536; i++) begin
            a16      = 16'(i);
            mem[a16] = a16[15:8] ^ a16[7:0] ^ 8'hA5;
        end

        code_pc = 16'h0000;
        emit(8'hC3);
        emit(8'h00);
        emit(8'h01);
        code_pc = 16'h0100;
        r0 = 8'($urandom_range(255));
        r1 = 8'($urandom_range(255));
        r2 = 8'($urandom_range(255));
        r3 = 8'($urandom_range(255));
        emit(8'h06);
        emit(r0);
        emit(8'h0E);
        emit(r1);
        emit(8'h16);
        emit(r2);
        emit(8'h1E);
        emit(r3);
        emit(8'h26);
        emit(8'hC0);
        emit(8'h2E);
        emit(8'h00);
        emit(8'h78);
        emit(8'h77);
        expect_write(16'hC000, r0);
        emit(8'h79);
        emit(8'h77);
        expect_write(16'hC000, r1);
        emit(8'h7A);
        emit(8'h77);
        expect_write(16'hC000, r2);
        emit(8'h7B);
        emit(8'h77);
        expect_write(16'hC000, r3);
        for (i = 0; i < 8; i++) begin
            run_alu(3'(i), 8'($urandom_range(255)), 8'($urandom_range(255)), 1'b1);
        end
        // Z set and C clear
        run_alu(3'd6, 8'h00, 8'h00, 1'b0);
        for (i = 0; i < 4; i++) begin
            jp_case(2'(i), 8'h30 + 8'(2 * i));
        end
        // Z clear and C set
        run_alu(3'd2, 8'h01, 8'h02, 1'b0);
        for (i = 0; i < 4; i++) begin
            jp_case(2'(i), 8'h40 + 8'(2 * i));
        end

        // EI and one more instruction before the store that gets displaced
        emit(8'hFB);
        emit(8'h3E);
        emit(8'h5A);
        ret_addr = code_pc;
        emit(8'h77);
        expect_write(16'hFFFD, ret_addr[15:8]);
        expect_write(16'hFFFC, ret_addr[7:0]);
        expect_write(16'hC000, 8'hA5);
        expect_write(16'hC000, 8'hA5);
        emit(8'h3E);
        emit(8'hD0);
        emit(8'h77);
        expect_write(16'hC000, 8'hD0);
        self_addr = code_pc;
        emit(8'hC3);
        emit(self_addr[7:0]);
        emit(self_addr[15:8]);

        // Handler at 40 stores, runs EI then DI and jumps back
        code_pc = 16'h0040;
        emit(8'h3E);
        emit(8'hA5);
        emit(8'h77);
        emit(8'hFB);
        emit(8'hF3);
        emit(8'hC3);
        emit(ret_addr[7:0]);
        emit(ret_addr[15:8]);
        table_ready = 1'b1;

        @(negedge reset);
        #1;
        check_value("addr_o", 16'h0000, addr);
        @(posedge clk);
        #20;
        check_value("addr_o", 16'h0001, addr);
        @(posedge clk);
        #20;
        check_value("addr_o", 16'h0002, addr);

        while (exp_addr_q.size() > 0) begin
            while (wr_addr_q.size() == 0) begin
                @(negedge clk);
            end
            check_value("write address", exp_addr_q.pop_front(), wr_addr_q.pop_front());
            check_value("write data", {8'h00, exp_data_q.pop_front()},
                        {8'h00, wr_data_q.pop_front()});
        end

        // Pending bit 2 must not start another dispatch
        repeat (20) @(negedge clk);
        check_value("extra writes", 16'd0, 16'(wr_addr_q.size()));
        check_value("clear_irq_o pulses", 16'd1, 16'(irq_pulses));
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);
    initial begin
        clk_o   = 1'b0;
        reset_o = 1'b1;
        forever #50 clk_o = ~clk_o;
    end

    // Reset drops just after the eighth rising edge
    initial begin
        repeat (8) @(posedge clk_o);
        #10;
        reset_o = 1'b0;
    end

endmodule

`default_nettype wire

// ==== hw/gb_cpu.sv ====
`default_nettype none

module gb_cpu (
    input  logic        clk,
    input  logic        reset,
    input  logic [7:0]  data_i,
    input  logic [4:0]  reg_if_i,
    input  logic [4:0]  reg_ie_i,
    output logic [15:0] addr_o,
    output logic [7:0]  data_o,
    output logic        drive_data_bus_o,
    output logic        clear_irq_o
);
    import gb_isa_pkg::*;
    import gb_core_pkg::*;

    regs_t      regs;
    schedule_t  sched;
    ctrl_t      ctrl;
    alu_req_t   alu_req;
    logic [7:0] alu_res;
    flags_t     alu_flags;
    logic       irq_pending;
    logic       isr;
    logic [7:0] vector;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath muxes

    assign alu_req.op  = ctrl.alu_op;
    assign alu_req.a   = get8(regs, ctrl.src_a);
    assign alu_req.b   = get8(regs, ctrl.src_b);
    assign alu_req.cin = regs.f[4];

    always_comb begin
        case (ctrl.addr_src)
            ADDR_PC:  addr_o = regs.pc;
            ADDR_HL:  addr_o = {regs.h, regs.l};
            ADDR_TMP: addr_o = {regs.tmp_hi, regs.tmp_lo};
            // Pushes land one below SP
            default:  addr_o = regs.sp - 16'd1;
        endcase
    end

    assign data_o           = get8(regs, ctrl.data_src);
    assign drive_data_bus_o = ctrl.drive_bus;
    assign clear_irq_o      = ctrl.clr_irq;

    ////////////////////////////////////////////////////////////////////////////
    // Sub-blocks

    gb_irq_ctrl u_irq_ctrl (
        .clk           (clk),
        .reset         (reset),
        .if_i          (reg_if_i),
        .ie_i          (reg_ie_i),
        .ctrl_i        (ctrl),
        .irq_pending_o (irq_pending),
        .vector_o      (vector)
    );

    gb_decoder u_decoder (
        .opcode_i (regs.ir),
        .isr_i    (isr),
        .sched_o  (sched)
    );

    gb_scheduler u_scheduler (
        .clk           (clk),
        .reset         (reset),
        .sched_i       (sched),
        .flags_i       (flags_t'(regs.f[7:4])),
        .cond_i        (cond_e'(regs.ir[4:3])),
        .irq_pending_i (irq_pending),
        .ctrl_o        (ctrl),
        .isr_o         (isr)
    );

    gb_alu u_alu (
        .req_i    (alu_req),
        .result_o (alu_res),
        .flags_o  (alu_flags)
    );

    gb_regfile u_regfile (
        .clk         (clk),
        .reset       (reset),
        .ctrl_i      (ctrl),
        .alu_res_i   (alu_res),
        .alu_flags_i (alu_flags),
        .bus_data_i  (data_i),
        .vector_i    (vector),
        .regs_o      (regs)
    );

endmodule

`default_nettype wire

// ==== hw/gb_regfile.sv ====
`default_nettype none

module gb_regfile (
    input  logic                clk,
    input  logic                reset,
    input  gb_core_pkg::ctrl_t  ctrl_i,
    input  logic [7:0]          alu_res_i,
    input  gb_core_pkg::flags_t alu_flags_i,
    input  logic [7:0]          bus_data_i,
    input  logic [7:0]          vector_i,
    output gb_core_pkg::regs_t  regs_o
);
    import gb_isa_pkg::*;
    import gb_core_pkg::*;

    regs_t       regs_q;
    regs_t       regs_d;
    logic [15:0] pc_base;

    ////////////////////////////////////////////////////////////////////////////
    // Write ports, later ones take priority

    always_comb begin
        regs_d = regs_q;
        if (ctrl_i.bus_rd_wren) begin
            regs_d = set8(regs_d, ctrl_i.bus_rd_dst, bus_data_i);
        end
        if (ctrl_i.alu_wren) begin
            regs_d = set8(regs_d, ctrl_i.alu_dst, alu_res_i);
        end
        if (ctrl_i.flags_wren) begin
            regs_d.f = {alu_flags_i, 4'h0};
        end
        if (ctrl_i.fetch) begin
            regs_d.ir = bus_data_i;
        end

        // Jump target fetch runs from TMP, so PC ends at target plus one
        pc_base = ctrl_i.pc_load_tmp ? {regs_q.tmp_hi, regs_q.tmp_lo} : regs_q.pc;
        if (ctrl_i.load_vector) begin
            regs_d.pc = {8'h00, vector_i};
        end else if (ctrl_i.clr_irq) begin
            // Undo the fetch of the instruction the ISR displaced
            regs_d.pc = regs_q.pc - 16'd1;
        end else begin
            regs_d.pc = pc_base + {15'd0, ctrl_i.pc_inc};
        end

        if (ctrl_i.sp_dec) begin
            regs_d.sp = regs_q.sp - 16'd1;
        end
    end

    always_ff @(posedge clk) begin
        regs_q <= regs_d;
        if (reset) begin
            regs_q.pc <= 16'h0000;
            regs_q.sp <= SP_RESET;
            regs_q.ir <= OPC_NOP;
            regs_q.a  <= 8'h00;
            regs_q.f  <= 8'h00;
        end
    end

    assign regs_o = regs_q;

endmodule

`default_nettype wire

// ==== hw/gb_alu.sv ====
`default_nettype none

module gb_alu (
    input  gb_core_pkg::alu_req_t req_i,
    output logic [7:0]            result_o,
    output gb_core_pkg::flags_t   flags_o
);
    import gb_isa_pkg::*;

    logic       cin;
    logic [8:0] sum;
    logic [8:0] diff;
    logic [4:0] half_sum;
    logic [4:0] half_diff;

    // Carry in only for ADC and SBC
    assign cin = (req_i.op == ALU_ADC || req_i.op == ALU_SBC) ? req_i.cin : 1'b0;

    assign sum       = {1'b0, req_i.a} + {1'b0, req_i.b} + {8'h00, cin};
    assign diff      = {1'b0, req_i.a} - {1'b0, req_i.b} - {8'h00, cin};
    assign half_sum  = {1'b0, req_i.a[3:0]} + {1'b0, req_i.b[3:0]} + {4'h0, cin};
    assign half_diff = {1'b0, req_i.a[3:0]} - {1'b0, req_i.b[3:0]} - {4'h0, cin};

    always_comb begin
        flags_o = '0;
        case (req_i.op)
            ALU_ADD, ALU_ADC: begin
                result_o  = sum[7:0];
                flags_o.h = half_sum[4];
                flags_o.c = sum[8];
            end
            ALU_SUB, ALU_SBC, ALU_CP: begin
                // Bit 4 and bit 8 of the difference are the borrows
                result_o  = diff[7:0];
                flags_o.n = 1'b1;
                flags_o.h = half_diff[4];
                flags_o.c = diff[8];
            end
            ALU_AND: begin
                result_o  = req_i.a & req_i.b;
                flags_o.h = 1'b1;
            end
            ALU_XOR: begin
                result_o = req_i.a ^ req_i.b;
            end
            default: begin
                result_o = req_i.a | req_i.b;
            end
        endcase
        flags_o.z = (result_o == 8'h00);
    end

endmodule

`default_nettype wire

// ==== hw/gb_scheduler.sv ====
`default_nettype none

module gb_scheduler (
    input  logic                   clk,
    input  logic                   reset,
    input  gb_core_pkg::schedule_t sched_i,
    input  gb_core_pkg::flags_t    flags_i,
    input  gb_isa_pkg::cond_e      cond_i,
    input  logic                   irq_pending_i,
    output gb_core_pkg::ctrl_t     ctrl_o,
    output logic                   isr_o
);
    import gb_isa_pkg::*;
    import gb_core_pkg::*;

    logic [2:0] cyc_q;
    logic       skip_q;
    logic       isr_q;
    logic       cond_ok;
    logic       wrap;

    always_comb begin
        case (cond_i)
            COND_NZ: cond_ok = ~flags_i.z;
            COND_Z:  cond_ok = flags_i.z;
            COND_NC: cond_ok = ~flags_i.c;
            default: cond_ok = flags_i.c;
        endcase
    end

    // A failed condition replaces the rest of the jump with a plain fetch
    assign ctrl_o = skip_q ? fetch_ctrl() : sched_i.cyc[cyc_q];
    assign wrap   = skip_q || (cyc_q == sched_i.len - 3'd1);
    assign isr_o  = isr_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            cyc_q  <= 3'd0;
            skip_q <= 1'b0;
            isr_q  <= 1'b0;
        end else if (wrap) begin
            // Instruction boundary, the next schedule may be the ISR
            cyc_q  <= 3'd0;
            skip_q <= 1'b0;
            isr_q  <= irq_pending_i;
        end else if (ctrl_o.cc_check && !cond_ok) begin
            skip_q <= 1'b1;
        end else begin
            cyc_q  <= cyc_q + 3'd1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/gb_decoder.sv ====
`default_nettype none

module gb_decoder (
    input  logic [7:0]             opcode_i,
    input  logic                   isr_i,
    output gb_core_pkg::schedule_t sched_o
);
    import gb_isa_pkg::*;
    import gb_core_pkg::*;

    reg8_sel_e dst;
    reg8_sel_e src;

    assign dst = reg_from_code(opcode_i[5:3]);
    assign src = reg_from_code(opcode_i[2:0]);

    // Operand byte read at PC
    function automatic ctrl_t imm_read(reg8_sel_e d);
        ctrl_t w;
        w = '0;
        w.addr_src    = ADDR_PC;
        w.bus_rd_dst  = d;
        w.bus_rd_wren = 1'b1;
        w.pc_inc      = 1'b1;
        return w;
    endfunction

    // Byte write to SP-1, SP steps down
    function automatic ctrl_t push(reg8_sel_e s);
        ctrl_t w;
        w = '0;
        w.addr_src  = ADDR_SP;
        w.drive_bus = 1'b1;
        w.data_src  = s;
        w.sp_dec    = 1'b1;
        return w;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Per-opcode schedules

    always_comb begin
        sched_o        = '0;
        sched_o.len    = 3'd1;
        sched_o.cyc[0] = fetch_ctrl();

        if (isr_i) begin
            sched_o.len            = 3'd5;
            sched_o.cyc[0]         = '0;
            sched_o.cyc[0].clr_irq = 1'b1;
            sched_o.cyc[2]         = push(R_PC_HI);
            sched_o.cyc[3]         = push(R_PC_LO);
            sched_o.cyc[3].load_vector = 1'b1;
            sched_o.cyc[4]         = fetch_ctrl();
        end else if (opcode_i == OPC_LD_HL_A) begin
            sched_o.len                = 3'd2;
            sched_o.cyc[0]             = '0;
            sched_o.cyc[0].addr_src    = ADDR_HL;
            sched_o.cyc[0].drive_bus   = 1'b1;
            sched_o.cyc[0].data_src    = R_A;
            sched_o.cyc[1]             = fetch_ctrl();
        end else if (opcode_i == OPC_JP || opcode_i ==? 8'b110??010) begin
            // Low byte, high byte, idle, fetch at the target
            sched_o.len                 = 3'd4;
            sched_o.cyc[0]              = imm_read(R_TMP_LO);
            sched_o.cyc[1]              = imm_read(R_TMP_HI);
            sched_o.cyc[1].cc_check     = (opcode_i != OPC_JP);
            sched_o.cyc[3]              = fetch_ctrl();
            sched_o.cyc[3].addr_src     = ADDR_TMP;
            sched_o.cyc[3].pc_load_tmp  = 1'b1;
        end else if (opcode_i == OPC_DI) begin
            sched_o.cyc[0].di = 1'b1;
        end else if (opcode_i == OPC_EI) begin
            sched_o.cyc[0].ei = 1'b1;
        end else if (opcode_i ==? 8'b00???110 && opcode_i[5:3] != REG_CODE_HL) begin
            sched_o.len    = 3'd2;
            sched_o.cyc[0] = imm_read(dst);
            sched_o.cyc[1] = fetch_ctrl();
        end else if (opcode_i[7:6] == 2'b01 && opcode_i[5:3] != REG_CODE_HL
                     && opcode_i[2:0] != REG_CODE_HL) begin
            // Register move runs as OR of the source with itself, flags untouched
            sched_o.cyc[0].alu_op   = ALU_OR;
            sched_o.cyc[0].src_a    = src;
            sched_o.cyc[0].src_b    = src;
            sched_o.cyc[0].alu_dst  = dst;
            sched_o.cyc[0].alu_wren = 1'b1;
        end else if (opcode_i[7:6] == 2'b10 && opcode_i[2:0] != REG_CODE_HL) begin
            sched_o.cyc[0].alu_op     = alu_op_e'(opcode_i[5:3]);
            sched_o.cyc[0].src_a      = R_A;
            sched_o.cyc[0].src_b      = src;
            sched_o.cyc[0].alu_dst    = R_A;
            sched_o.cyc[0].flags_wren = 1'b1;
            // CP only compares
            sched_o.cyc[0].alu_wren   = (opcode_i[5:3] != ALU_CP);
        end
    end

endmodule

`default_nettype wire

// ==== hw/gb_irq_ctrl.sv ====
`default_nettype none

module gb_irq_ctrl (
    input  logic               clk,
    input  logic               reset,
    input  logic [4:0]         if_i,
    input  logic [4:0]         ie_i,
    input  gb_core_pkg::ctrl_t ctrl_i,
    output logic               irq_pending_o,
    output logic [7:0]         vector_o
);
    import gb_isa_pkg::*;

    logic       ime_q;
    logic       ei_pend_q;
    logic [4:0] req;
    logic [7:0] vector_d;
    logic [7:0] vector_q;

    assign req = if_i & ie_i;

    // A pending EI already counts at the end of the following instruction
    assign irq_pending_o = (ime_q | ei_pend_q) & ~ctrl_i.di & (req != 5'd0);

    // Lowest set bit wins
    always_comb begin
        vector_d = IRQ_VECTOR[0];
        for (int i = 4; i >= 0; i--) begin
            if (req[i]) begin
                vector_d = IRQ_VECTOR[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || ctrl_i.di || ctrl_i.clr_irq) begin
            ime_q     <= 1'b0;
            ei_pend_q <= 1'b0;
        end else if (ctrl_i.ei) begin
            ei_pend_q <= 1'b1;
        end else if (ctrl_i.last && ei_pend_q) begin
            ime_q     <= 1'b1;
            ei_pend_q <= 1'b0;
        end
    end

    // Vector is frozen while the flag bit is still set
    always_ff @(posedge clk) begin
        if (ctrl_i.clr_irq) begin
            vector_q <= vector_d;
        end
    end

    assign vector_o = vector_q;

endmodule

`default_nettype wire

// ==== hw/gb_core_pkg.sv ====
`default_nettype none

package gb_core_pkg;
    import gb_isa_pkg::*;

    localparam logic [15:0] SP_RESET   = 16'hFFFE;
    localparam int          MAX_CYCLES = 5;

    typedef struct packed {
        logic z;
        logic n;
        logic h;
        logic c;
    } flags_t;

    // Flags sit in the upper nibble of f
    typedef struct packed {
        logic [7:0]  a;
        logic [7:0]  f;
        logic [7:0]  b, c, d, e, h, l;
        logic [7:0]  tmp_hi, tmp_lo;
        logic [15:0] sp;
        logic [15:0] pc;
        logic [7:0]  ir;
    } regs_t;

    // Control word for one M-cycle
    typedef struct packed {
        alu_op_e   alu_op;
        logic      alu_wren;
        reg8_sel_e alu_dst;
        reg8_sel_e src_a;
        reg8_sel_e src_b;
        logic      flags_wren;
        reg8_sel_e bus_rd_dst;
        logic      bus_rd_wren;
        addr_src_e addr_src;
        logic      drive_bus;
        reg8_sel_e data_src;
        logic      pc_inc;
        logic      pc_load_tmp;
        logic      sp_dec;
        logic      load_vector;
        logic      fetch;
        logic      cc_check;
        logic      ei;
        logic      di;
        logic      clr_irq;
        logic      last;
    } ctrl_t;

    typedef struct packed {
        ctrl_t [MAX_CYCLES-1:0] cyc;
        logic  [2:0]            len;
    } schedule_t;

    typedef struct packed {
        alu_op_e    op;
        logic [7:0] a;
        logic [7:0] b;
        logic       cin;
    } alu_req_t;

    function automatic logic [7:0] get8(regs_t r, reg8_sel_e sel);
        case (sel)
            R_B:      return r.b;
            R_C:      return r.c;
            R_D:      return r.d;
            R_E:      return r.e;
            R_H:      return r.h;
            R_L:      return r.l;
            R_A:      return r.a;
            R_F:      return r.f;
            R_TMP_LO: return r.tmp_lo;
            R_TMP_HI: return r.tmp_hi;
            R_PC_HI:  return r.pc[15:8];
            R_PC_LO:  return r.pc[7:0];
            R_SP_LO:  return r.sp[7:0];
            R_SP_HI:  return r.sp[15:8];
            default:  return 8'h00;
        endcase
    endfunction

    // PC and SP halves are not written through this port
    function automatic regs_t set8(regs_t r, reg8_sel_e sel, logic [7:0] v);
        regs_t n;
        n = r;
        case (sel)
            R_B:      n.b = v;
            R_C:      n.c = v;
            R_D:      n.d = v;
            R_E:      n.e = v;
            R_H:      n.h = v;
            R_L:      n.l = v;
            R_A:      n.a = v;
            R_F:      n.f = {v[7:4], 4'h0};
            R_TMP_LO: n.tmp_lo = v;
            R_TMP_HI: n.tmp_hi = v;
            default:  n = r;
        endcase
        return n;
    endfunction

    // Opcode fetch at PC, closes every instruction
    function automatic ctrl_t fetch_ctrl();
        ctrl_t w;
        w = '0;
        w.addr_src = ADDR_PC;
        w.fetch    = 1'b1;
        w.pc_inc   = 1'b1;
        w.last     = 1'b1;
        return w;
    endfunction

endpackage

`default_nettype wire

// ==== hw/gb_isa_pkg.sv ====
`default_nettype none

package gb_isa_pkg;

    // ALU operation, straight from opcode bits 5:3
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_ADC,
        ALU_SUB,
        ALU_SBC,
        ALU_AND,
        ALU_XOR,
        ALU_OR,
        ALU_CP
    } alu_op_e;

    // Condition code, opcode bits 4:3
    typedef enum logic [1:0] {
        COND_NZ,
        COND_Z,
        COND_NC,
        COND_C
    } cond_e;

    // 8-bit register selects; B to L keep the opcode numbering
    typedef enum logic [3:0] {
        R_B, R_C, R_D, R_E, R_H, R_L, R_A, R_F,
        R_TMP_LO, R_TMP_HI, R_PC_HI, R_PC_LO, R_SP_LO, R_SP_HI
    } reg8_sel_e;

    typedef enum logic [1:0] {
        ADDR_PC,
        ADDR_HL,
        ADDR_TMP,
        ADDR_SP
    } addr_src_e;

    localparam logic [7:0] OPC_NOP     = 8'h00;
    localparam logic [7:0] OPC_LD_HL_A = 8'h77;
    localparam logic [7:0] OPC_JP      = 8'hC3;
    localparam logic [7:0] OPC_DI      = 8'hF3;
    localparam logic [7:0] OPC_EI      = 8'hFB;
    localparam logic [2:0] REG_CODE_HL = 3'b110;

    // Index 0 is the highest priority source
    localparam logic [4:0][7:0] IRQ_VECTOR = {8'h60, 8'h58, 8'h50, 8'h48, 8'h40};

    // Opcode register field to select; code 111 is A
    function automatic reg8_sel_e reg_from_code(logic [2:0] code);
        return (code == 3'b111) ? R_A : reg8_sel_e'({1'b0, code});
    endfunction

endpackage

`default_nettype wire
